// ==== design/progress_pkg.sv ====
//##################################################
// Progress controller shared types
// Widths, address regions, size codes, ack states
//##################################################
package progress_pkg;

   // Widths with a meaning on the bus side
   localparam int ADDR_W   = 32;   // Address / operand word
   localparam int SEL_W    = 4;    // One select per byte lane
   localparam int SIZE_W   = 4;    // Microcode access-size field
   localparam int REGION_W = 4;    // Top nibble decides the region

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [SEL_W-1:0]    byte_sel_t;
   typedef logic [SIZE_W-1:0]   size_code_t;
   typedef logic [REGION_W-1:0] region_t;

   // Control registers live at 0x2xxx_xxxx
   localparam region_t REGION_CTRLREG = 4'b0010;

   // Access sizes from microcode
   // Any code not listed here means a full word
   localparam size_code_t SIZE_HALF = 4'b0001;
   localparam size_code_t SIZE_BYTE = 4'b0010;

   // Acknowledge qualifier states
   // ACK_HELD is entered when a slave keeps its ack high with no strobe out
   typedef enum logic {
      ACK_NORMAL = 1'b0,   // Ack is trusted only together with the strobe
      ACK_HELD   = 1'b1    // Slave holds ack, the strobe itself acknowledges
   } ack_state_t;

endpackage

// ==== design/byte_select_reg.sv ====
//##################################################
// Byte select register
// Decodes size and offset, latches sel and bmask
//##################################################
`timescale 1ns/1ps

module byte_select_reg (
   input  logic                   clk,
   input  logic                   RST_I,
   input  logic                   latch_sel,   // Microcode pulse, take new selects
   input  progress_pkg::size_code_t size_code,
   input  logic [1:0]             addr_low,    // Byte offset within the word
   output progress_pkg::byte_sel_t  sel,
   output progress_pkg::byte_sel_t  bmask       // Active low copy of sel
);
   import progress_pkg::*;

   byte_sel_t dec_sel;   // Decoded lanes, not yet latched

   // Size and offset to lanes
   always_comb begin
      case (size_code)
         SIZE_HALF: begin
            case (addr_low)
               2'b00:   dec_sel = 4'b0011;   // Lower half
               2'b10:   dec_sel = 4'b1100;   // Upper half
               default: dec_sel = 4'b1111;   // Odd offset gives all lanes
            endcase
         end
         SIZE_BYTE: begin
            // One hot on the offset
            dec_sel = byte_sel_t'(4'b0001 << addr_low);
         end
         default: begin
            dec_sel = 4'b1111;   // Word access
         end
      endcase
   end

   // Latched on the microcode pulse, held otherwise
   always_ff @(posedge clk) begin
      if (RST_I) begin
         sel   <= 4'b0000;
         bmask <= 4'b1111;     // Inverse of the cleared sel
      end else if (latch_sel) begin
         sel   <= dec_sel;
         bmask <= ~dec_sel;   // Register file wants it active low
      end
   end

endmodule

// ==== design/bus_strobe_ctrl.sv ====
//##################################################
// Bus strobe control
// Alignment check, I/O and SRAM strobes held to ack
//##################################################
`timescale 1ns/1ps

module bus_strobe_ctrl #(
   parameter bit has_sram = 1'b1   // Build the SRAM strobe
) (
   input  logic               clk,
   input  logic               RST_I,
   input  logic               core_running,
   input  logic               word_store,   // Current access is a word store
   input  logic               req_access,   // Microcode asks for a bus cycle
   input  logic               bus_error,
   input  logic               qack,         // Qualified I/O acknowledge
   input  logic               sram_ack,
   input  progress_pkg::addr_t addr,
   output logic               misaligned,
   output logic               io_stb,
   output logic               sram_stb
);

   logic io_start;   // New I/O cycle this edge

   // Not running counts as misaligned, so nothing starts before the core does
   // A word store must sit on a word boundary, halfwords are checked earlier
   assign misaligned = !core_running || (word_store && (addr[1:0] != 2'b00));

   // I/O space is 0x4xxx_xxxx to 0x7xxx_xxxx
   assign io_start = req_access && (addr[31:30] == 2'b01) && !misaligned;

   // Raised on request, held until the qualified ack
   always_ff @(posedge clk) begin
      if (RST_I || bus_error) begin
         io_stb <= 1'b0;   // Bus error abandons the cycle
      end else begin
         io_stb <= io_start || (io_stb && !qack);
      end
   end

   generate
      if (has_sram) begin : g_sram
         logic sram_start;

         // SRAM is the upper half of the address space
         assign sram_start = req_access && addr[31] && !misaligned;

         // Same hold rule, ended by the SRAM's own ack
         always_ff @(posedge clk) begin
            if (RST_I || bus_error) begin
               sram_stb <= 1'b0;
            end else begin
               sram_stb <= sram_start || (sram_stb && !sram_ack);
            end
         end
      end else begin : g_no_sram
         // No SRAM fitted
         assign sram_stb = 1'b0;
      end
   endgenerate

endmodule

// ==== design/write_enable_ctrl.sv ====
//##################################################
// Write enable control
// Bus and control-register write enables
//##################################################
`timescale 1ns/1ps

module write_enable_ctrl (
   input  logic               clk,
   input  logic               RST_I,
   input  logic               req_write,    // Microcode pulse, set enables
   input  logic               end_write,    // Microcode pulse, clear enables
   input  logic               bus_error,
   input  logic               misaligned,   // From the strobe block
   input  progress_pkg::addr_t addr,
   output logic               io_we,        // Write to I/O or SRAM
   output logic               ctrlreg_we    // Write to the control registers
);
   import progress_pkg::*;

   region_t region;        // Top nibble of the address
   logic    io_we_nxt;
   logic    ctrl_we_nxt;

   assign region = addr[ADDR_W-1 -: REGION_W];

   // Any address with one of the two top bits set goes out on the bus
   assign io_we_nxt   = (addr[31] || addr[30]) && !misaligned;

   // Control registers sit inside the internal space
   assign ctrl_we_nxt = (region == REGION_CTRLREG) && !misaligned;

   always_ff @(posedge clk) begin
      if (RST_I || end_write || bus_error) begin
         io_we      <= 1'b0;
         ctrlreg_we <= 1'b0;
      end else if (req_write) begin
         io_we      <= io_we_nxt;
         ctrlreg_we <= ctrl_we_nxt;
      end
   end

endmodule

// ==== design/ack_qualifier.sv ====
//##################################################
// Acknowledge qualifier
// Merges acks, recovers from a slave holding ack
//##################################################
`timescale 1ns/1ps

module ack_qualifier (
   input  logic clk,
   input  logic RST_I,
   input  logic io_ack,       // Raw ack from the I/O slave
   input  logic sysreg_ack,   // Ack from the system registers
   input  logic io_stb,       // Our I/O strobe
   output logic qack          // Qualified ack, same cycle
);
   import progress_pkg::*;

   ack_state_t state;
   ack_state_t next_state;

   // A single zero wait state slave may tie its ack high
   // Seen as ack without strobe, after which the strobe stands in for the ack
   // Ack dropping again brings back normal qualification
   always_comb begin
      next_state = state;
      qack       = sysreg_ack;
      case (state)
         ACK_NORMAL: begin
            qack = sysreg_ack || (io_ack && io_stb);
            if (io_ack && !io_stb) begin
               next_state = ACK_HELD;   // Ack with no cycle out
            end
         end
         ACK_HELD: begin
            qack = sysreg_ack || io_stb;   // Slave answers at once
            if (!io_ack) begin
               next_state = ACK_NORMAL;
            end
         end
         default: begin
            next_state = ACK_NORMAL;
         end
      endcase
   end

   // State updates every cycle
   always_ff @(posedge clk) begin
      if (RST_I) begin
         state <= ACK_NORMAL;
      end else begin
         state <= next_state;
      end
   end

endmodule

// ==== design/ucode_progress.sv ====
//##################################################
// Microcode progress
// Advance, Q sample and register write enables
//##################################################
`timescale 1ns/1ps

module ucode_progress #(
   parameter bit has_sram = 1'b1   // SRAM strobe present
) (
   input  logic core_running,
   input  logic q_update,           // Q codes from microcode
   input  logic q_read,
   input  logic shift_until_zero,   // Repeat shift until count is zero
   input  logic last_shift,
   input  logic last_shift_r,
   input  logic bus_error,
   input  logic latch_sel,
   input  logic io_stb,
   input  logic sram_stb,
   input  logic io_we,
   output logic enable_q,           // Q register samples
   output logic progress,           // Microcode advances
   output logic reg_we              // Internal register file write
);

   logic busy;   // A bus cycle is still open

   assign busy = io_stb || (has_sram && sram_stb);

   // Q waits for the data of an open cycle
   assign enable_q = (q_update || q_read) && !last_shift && !busy;

   // Stall on an open cycle or an unfinished shift
   // Bus error always lets the microcode move on to its trap
   assign progress = bus_error ||
                     (!busy && (!shift_until_zero || last_shift || last_shift_r));

   // No write while setting selects, writing out, or on a zero shift
   // Core must be running so the first cycle writes nothing
   assign reg_we = core_running && !(latch_sel || io_we || last_shift_r);

endmodule

// ==== design/progress_ctrl.sv ====
//##################################################
// Progress controller top level
// Selects, strobes, write enables, ack, progress
//##################################################
`timescale 1ns/1ps

module progress_ctrl #(
   parameter bit has_sram = 1'b1   // Passed to strobe and progress blocks
) (
   input  logic                    clk,
   input  logic                    RST_I,
   input  logic                    core_running,
   input  progress_pkg::addr_t      addr,
   input  progress_pkg::size_code_t size_code,
   input  logic                    latch_sel,
   input  logic                    req_access,
   input  logic                    req_write,
   input  logic                    end_write,
   input  logic                    word_store,
   input  logic                    q_update,
   input  logic                    q_read,
   input  logic                    shift_until_zero,
   input  logic                    last_shift,
   input  logic                    last_shift_r,
   input  logic                    io_ack,
   input  logic                    sysreg_ack,
   input  logic                    sram_ack,
   input  logic                    bus_error,
   output progress_pkg::byte_sel_t  sel,
   output progress_pkg::byte_sel_t  bmask,
   output logic                    io_stb,
   output logic                    sram_stb,
   output logic                    io_we,
   output logic                    ctrlreg_we,
   output logic                    qack,
   output logic                    enable_q,
   output logic                    progress,
   output logic                    reg_we
);

   logic misaligned;   // Strobe block to write enables

   byte_select_reg u_byte_sel (
      .clk       (clk),
      .RST_I     (RST_I),
      .latch_sel (latch_sel),
      .size_code (size_code),
      .addr_low  (addr[1:0]),
      .sel       (sel),
      .bmask     (bmask)
   );

   bus_strobe_ctrl #(
      .has_sram (has_sram)
   ) u_strobe (
      .clk          (clk),
      .RST_I        (RST_I),
      .core_running (core_running),
      .word_store   (word_store),
      .req_access   (req_access),
      .bus_error    (bus_error),
      .qack         (qack),
      .sram_ack     (sram_ack),
      .addr         (addr),
      .misaligned   (misaligned),
      .io_stb       (io_stb),
      .sram_stb     (sram_stb)
   );

   write_enable_ctrl u_we (
      .clk        (clk),
      .RST_I      (RST_I),
      .req_write  (req_write),
      .end_write  (end_write),
      .bus_error  (bus_error),
      .misaligned (misaligned),
      .addr       (addr),
      .io_we      (io_we),
      .ctrlreg_we (ctrlreg_we)
   );

   // Qualified ack closes the I/O strobe
   ack_qualifier u_ack (
      .clk        (clk),
      .RST_I      (RST_I),
      .io_ack     (io_ack),
      .sysreg_ack (sysreg_ack),
      .io_stb     (io_stb),
      .qack       (qack)
   );

   ucode_progress #(
      .has_sram (has_sram)
   ) u_progress (
      .core_running     (core_running),
      .q_update         (q_update),
      .q_read           (q_read),
      .shift_until_zero (shift_until_zero),
      .last_shift       (last_shift),
      .last_shift_r     (last_shift_r),
      .bus_error        (bus_error),
      .latch_sel        (latch_sel),
      .io_stb           (io_stb),
      .sram_stb         (sram_stb),
      .io_we            (io_we),
      .enable_q         (enable_q),
      .progress         (progress),
      .reg_we           (reg_we)
   );

endmodule

// ==== testbench/progress_ctrl_asserts.sv ====
//##################################################
// Progress controller assertions
// Strobe, select, write enable and ack invariants
//##################################################
`timescale 1ns/1ps

module progress_ctrl_asserts (
   input  logic                     clk,
   input  logic                     RST_I,
   input  progress_pkg::byte_sel_t  sel,
   input  progress_pkg::byte_sel_t  bmask,
   input  logic                     io_stb,
   input  logic                     sram_stb,
   input  logic                     io_we,
   input  logic                     req_write,
   input  logic                     misaligned,
   input  progress_pkg::ack_state_t ack_state   // Qualifier FSM state
);
   import progress_pkg::*;

   // Only one bus cycle may be open at a time
   a_one_strobe: assert property (@(posedge clk) disable iff (RST_I) !(io_stb && sram_stb))
      else $error("io_stb and sram_stb high together");

   // Mask tracks selects
   a_bmask_inv: assert property (@(posedge clk) disable iff (RST_I) bmask == ~sel)
      else $error("bmask is not the inverse of sel");

   // A misaligned write must leave the bus enable off
   a_no_misaligned_we: assert property (@(posedge clk) disable iff (RST_I)
      (req_write && misaligned) |=> !io_we)
      else $error("io_we set on a misaligned request");

   a_ack_after_reset: assert property (@(posedge clk) RST_I |=> ack_state == ACK_NORMAL)
      else $error("ack state not normal after reset");

endmodule

// Attach to every progress_ctrl instance
bind progress_ctrl progress_ctrl_asserts u_asserts (
   .clk        (clk),
   .RST_I      (RST_I),
   .sel        (sel),
   .bmask      (bmask),
   .io_stb     (io_stb),
   .sram_stb   (sram_stb),
   .io_we      (io_we),
   .req_write  (req_write),
   .misaligned (misaligned),
   .ack_state  (u_ack.state)
);

// ==== testbench/tb_progress_ctrl.sv ====
//##################################################
// Progress controller testbench
// Vector file driven, checks all ten outputs
//##################################################
`timescale 1ns/1ps

module tb_progress_ctrl;
   import progress_pkg::*;

   localparam int PERIOD       = 4;
   localparam int RESET_CYCLES = 8;
   localparam int MARGIN       = 20;    // Spare cycles for the watchdog
   localparam int MAX_VEC      = 256;
   localparam int NUM_FIELDS   = 27;    // 17 inputs then 10 outputs

   logic       clk = 1'b0;
   logic       RST_I;
   logic       core_running;
   addr_t      addr;
   size_code_t size_code;
   logic       latch_sel, req_access, req_write, end_write, word_store;
   logic       q_update, q_read, shift_until_zero, last_shift, last_shift_r;
   logic       io_ack, sysreg_ack, sram_ack, bus_error;
   byte_sel_t  sel, bmask;
   logic       io_stb, sram_stb, io_we, ctrlreg_we, qack, enable_q, progress, reg_we;

   logic [31:0] vec [0:MAX_VEC-1][0:NUM_FIELDS-1];   // Parsed vector fields
   int          num_vec = 0;
   int          errors  = 0;
   bit          loaded  = 1'b0;

   always #(PERIOD/2) clk = ~clk;

   progress_ctrl #(.has_sram(1'b1)) dut_i (
      .clk (clk), .RST_I (RST_I), .core_running (core_running), .addr (addr),
      .size_code (size_code), .latch_sel (latch_sel), .req_access (req_access),
      .req_write (req_write), .end_write (end_write), .word_store (word_store),
      .q_update (q_update), .q_read (q_read), .shift_until_zero (shift_until_zero),
      .last_shift (last_shift), .last_shift_r (last_shift_r), .io_ack (io_ack),
      .sysreg_ack (sysreg_ack), .sram_ack (sram_ack), .bus_error (bus_error),
      .sel (sel), .bmask (bmask), .io_stb (io_stb), .sram_stb (sram_stb),
      .io_we (io_we), .ctrlreg_we (ctrlreg_we), .qack (qack), .enable_q (enable_q),
      .progress (progress), .reg_we (reg_we)
   );

   // Reads the vector file, skips comment and blank lines
   task automatic load_vectors();
      int          fd;
      int          code;
      string       line;
      logic [31:0] f [0:NUM_FIELDS-1];
      fd = $fopen("testbench/progress_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file");
         errors++;
         return;
      end
      while (!$feof(fd) && num_vec < MAX_VEC) begin
         code = $fgets(line, fd);
         if (code == 0 || line.len() == 0 || line.getc(0) == "#") continue;
         code = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
            f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
            f[22], f[23], f[24], f[25], f[26]);
         if (code == NUM_FIELDS) begin
            for (int k = 0; k < NUM_FIELDS; k++) vec[num_vec][k] = f[k];
            num_vec++;
         end else if (code > 0) begin
            $display("Vector line %0d has too few fields", num_vec);   // Malformed line
            errors++;
         end
      end
      $fclose(fd);
   endtask

   // Inputs on the rising edge
   task automatic drive_vector(input int i);
      core_running     <= vec[i][0][0];
      addr             <= vec[i][1];
      size_code        <= vec[i][2][3:0];
      latch_sel        <= vec[i][3][0];
      req_access       <= vec[i][4][0];
      req_write        <= vec[i][5][0];
      end_write        <= vec[i][6][0];
      word_store       <= vec[i][7][0];
      q_update         <= vec[i][8][0];
      q_read           <= vec[i][9][0];
      shift_until_zero <= vec[i][10][0];
      last_shift       <= vec[i][11][0];
      last_shift_r     <= vec[i][12][0];
      io_ack           <= vec[i][13][0];
      sysreg_ack       <= vec[i][14][0];
      sram_ack         <= vec[i][15][0];
      bus_error        <= vec[i][16][0];
   endtask

   task automatic check_field(input int i, input string name,
                              input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] vector %0d %s expected %h got %h", i, name, exp, got);
         errors++;
      end
   endtask

   task automatic check_vector(input int i);
      check_field(i, "sel",        32'(sel),        vec[i][17]);
      check_field(i, "bmask",      32'(bmask),      vec[i][18]);
      check_field(i, "io_stb",     32'(io_stb),     vec[i][19]);
      check_field(i, "sram_stb",   32'(sram_stb),   vec[i][20]);
      check_field(i, "io_we",      32'(io_we),      vec[i][21]);
      check_field(i, "ctrlreg_we", 32'(ctrlreg_we), vec[i][22]);
      check_field(i, "qack",       32'(qack),       vec[i][23]);
      check_field(i, "enable_q",   32'(enable_q),   vec[i][24]);
      check_field(i, "progress",   32'(progress),   vec[i][25]);
      check_field(i, "reg_we",     32'(reg_we),     vec[i][26]);
   endtask

   // Watchdog sized from the vector count
   initial begin
      int limit;
      wait (loaded);
      limit = (num_vec + RESET_CYCLES + MARGIN) * PERIOD;
      #(limit);
      $display("Timeout, the vectors did not finish in time");
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      RST_I            = 1'b1;   // All inputs idle during reset
      core_running     = 1'b0;
      addr             = '0;
      size_code        = '0;
      latch_sel        = 1'b0;
      req_access       = 1'b0;
      req_write        = 1'b0;
      end_write        = 1'b0;
      word_store       = 1'b0;
      q_update         = 1'b0;
      q_read           = 1'b0;
      shift_until_zero = 1'b0;
      last_shift       = 1'b0;
      last_shift_r     = 1'b0;
      io_ack           = 1'b0;
      sysreg_ack       = 1'b0;
      sram_ack         = 1'b0;
      bus_error        = 1'b0;
      load_vectors();
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      RST_I <= 1'b0;
      for (int i = 0; i < num_vec; i++) begin
         @(posedge clk);
         drive_vector(i);
         @(negedge clk);   // Mid cycle where the outputs have settled
         check_vector(i);
      end
      $display("Errors: %0d over %0d vectors", errors, num_vec);
      if (errors == 0 && num_vec > 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== testbench/progress_tests.txt ====
# cr addr sz latch rqa rqw endw wst qupd qrd suz lsh lsr ioack sysack sramack berr
# then expected: sel bmask io_stb sram_stb io_we ctrlreg_we qack enable_q progress reg_we
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  0 f 0 0 0 0 0 0 1 1
1 00000002 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0  0 f 0 0 0 0 0 0 1 0
1 00000001 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0  4 b 0 0 0 0 0 0 1 0
1 00000002 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 0
1 00000000 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0  c 3 0 0 0 0 0 0 1 0
1 00000003 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0  3 c 0 0 0 0 0 0 1 0
1 00000000 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 40000000 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 40000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 1 0 0 0 0 0 0 1
1 40000000 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0  f 0 1 0 0 0 0 0 0 1
1 40000000 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0  f 0 1 0 0 0 1 0 0 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 40000001 0 0 1 0 0 1 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 80000000 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 80000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 1 0 0 0 0 0 1
1 80000000 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0  f 0 0 1 0 0 0 0 0 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 80000004 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 80000004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1  f 0 0 1 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 80000000 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 1 0 0 0 1 0
1 00000000 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0  f 0 0 0 1 0 0 0 1 0
1 40000000 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 20000000 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 1 0 0 0 1 0
1 00000000 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 1 0 0 1 1
1 20000003 0 0 0 1 0 1 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0  f 0 0 0 0 0 0 0 1 1
1 40000000 0 0 1 0 0 0 0 0 0 0 0 1 0 0 0  f 0 0 0 0 0 0 0 1 1
1 40000000 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0  f 0 1 0 0 0 1 0 0 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 40000000 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 40000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 1 0 0 0 0 0 0 1
1 40000000 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0  f 0 1 0 0 0 1 0 0 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0  f 0 0 0 0 0 1 0 1 1
1 00000000 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0  f 0 0 0 0 0 0 0 0 1
1 00000000 0 0 0 0 0 0 1 0 1 1 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 1 1 0 1 0 0 0 0  f 0 0 0 0 0 0 1 1 0
1 00000000 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 1 1 1
0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 0
0 00000000 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 0
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 1 0 0 0 0 0 1  f 0 0 0 0 0 0 0 1 1
1 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  f 0 0 0 0 0 0 0 1 1

// ==== compile.f ====
design/progress_pkg.sv
design/byte_select_reg.sv
design/bus_strobe_ctrl.sv
design/write_enable_ctrl.sv
design/ack_qualifier.sv
design/ucode_progress.sv
design/progress_ctrl.sv
testbench/progress_ctrl_asserts.sv
testbench/tb_progress_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the progress controller simulation with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f compile.f --top-module tb_progress_ctrl \
   -o sim_progress > build.log 2>&1 &&
./obj_dir/sim_progress > sim.log 2>&1 ;
grep -q '^>>> PASS$' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
